// File: src/reg_bus_macros.svh
`ifndef REG_BUS_MACROS_SVH
`define REG_BUS_MACROS_SVH

// ##################################################
// Bus widths
// ##################################################
`define REG_ADDR_W      16
`define REG_DATA_W      32

// ##################################################
// Address map
// ##################################################
`define BANK0_BASE      16'h0000
`define BANK1_BASE      16'h0100
`define BANK_WIN_BITS   8           // 256 byte window per bank

`define BANK_REGS       8

`endif

// File: src/reg_bus_pkg.sv
`default_nettype none

`include "reg_bus_macros.svh"

package reg_bus_pkg;

    // Native requester side
    typedef struct packed {
        logic                   wr_en;
        logic                   rd_en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`REG_DATA_W-1:0] wr_data;
    } reg_req_t;

    typedef struct packed {
        logic [`REG_DATA_W-1:0] rd_data;
        logic                   err;
    } reg_rsp_t;

    // Master fields shared by every APB slave
    typedef struct packed {
        logic                   penable;
        logic                   pwrite;
        logic [`REG_ADDR_W-1:0] paddr;
        logic [`REG_DATA_W-1:0] pwdata;
    } apb_m2s_t;

    typedef struct packed {
        logic [`REG_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_s2m_t;

endpackage

`default_nettype wire

// File: src/reg_native_if2apb.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_macros.svh"

module reg_native_if2apb import reg_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     req_vld,
    input  reg_req_t req,
    output logic     ack_vld,
    output reg_rsp_t rsp,

    output logic     psel,
    output apb_m2s_t m2s,
    input  apb_s2m_t s2m
);

    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_SETUP  = 2'd1,
        S_ACCESS = 2'd2
    } state_e;

    state_e                 state;
    state_e                 next_state;
    logic                   start;
    logic                   pwrite_q;
    logic [`REG_ADDR_W-1:0] paddr_q;
    logic [`REG_DATA_W-1:0] pwdata_q;

    assign start = req_vld && (req.wr_en || req.rd_en);   // Strobe without a command is dropped

    // ##################################################
    // FSM
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (start) begin
                    next_state = S_SETUP;
                end
            end
            S_SETUP: next_state = S_ACCESS;
            S_ACCESS: begin
                if (s2m.pready) begin
                    next_state = start ? S_SETUP : S_IDLE;   // Back-to-back in the ack cycle
                end
            end
            default: next_state = S_IDLE;
        endcase
    end

    // Request fields are taken on the way into setup and held until pready
    always_ff @(posedge clk) begin
        if (next_state == S_SETUP) begin
            pwrite_q <= req.wr_en;
            paddr_q  <= req.addr;
            pwdata_q <= req.wr_data;
        end
    end

    // ##################################################
    // Outputs
    // ##################################################
    assign psel = (state != S_IDLE);

    always_comb begin
        m2s.penable = (state == S_ACCESS);
        m2s.pwrite  = pwrite_q;
        m2s.paddr   = paddr_q;
        m2s.pwdata  = pwdata_q;
    end

    assign ack_vld     = s2m.pready;
    assign rsp.rd_data = s2m.prdata;
    assign rsp.err     = s2m.pslverr;

endmodule

`default_nettype wire

// File: src/apb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_macros.svh"

module apb_decoder import reg_bus_pkg::*; (
    input  logic                   psel,
    input  logic [`REG_ADDR_W-1:0] paddr,
    input  logic                   penable,
    input  apb_s2m_t               s2m0,
    input  apb_s2m_t               s2m1,

    output logic                   psel0,
    output logic                   psel1,
    output apb_s2m_t               s2m
);

    localparam int                     PAGE_W = `REG_ADDR_W - `BANK_WIN_BITS;
    localparam logic [`REG_ADDR_W-1:0] BASE0  = `BANK0_BASE;
    localparam logic [`REG_ADDR_W-1:0] BASE1  = `BANK1_BASE;

    logic [PAGE_W-1:0] page;
    logic              hit0;
    logic              hit1;
    logic              psel_def;
    apb_s2m_t          def_s2m;

    // Window match on the bits above the bank offset
    assign page = paddr[`REG_ADDR_W-1:`BANK_WIN_BITS];
    assign hit0 = (page == BASE0[`REG_ADDR_W-1:`BANK_WIN_BITS]);
    assign hit1 = (page == BASE1[`REG_ADDR_W-1:`BANK_WIN_BITS]);

    assign psel0    = psel && hit0;
    assign psel1    = psel && hit1;
    assign psel_def = psel && !hit0 && !hit1;

    // Default slave answers with an error in the first access cycle
    always_comb begin
        def_s2m.prdata  = '0;
        def_s2m.pready  = psel_def && penable;
        def_s2m.pslverr = psel_def && penable;
    end

    always_comb begin
        if (psel0) begin
            s2m = s2m0;
        end else if (psel1) begin
            s2m = s2m1;
        end else if (psel_def) begin
            s2m = def_s2m;
        end else begin
            s2m = '0;   // Idle bus
        end
    end

endmodule

`default_nettype wire

// File: src/apb_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_macros.svh"

module apb_reg_bank import reg_bus_pkg::*; #(
    parameter int WAIT_STATES = 0,
    parameter int NUM_REGS    = `BANK_REGS
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     psel,
    input  apb_m2s_t m2s,
    output apb_s2m_t s2m
);

    localparam int               OFS_W    = `BANK_WIN_BITS - 2;
    localparam int               IDX_W    = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
    localparam int               CNT_W    = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WAIT_STATES);

    logic [OFS_W-1:0]       word_ofs;
    logic [IDX_W-1:0]       idx;
    logic                   in_range;
    logic                   access;
    logic                   ready;
    logic [CNT_W-1:0]       wait_cnt;
    logic [`REG_DATA_W-1:0] regs [NUM_REGS];

    assign word_ofs = m2s.paddr[`BANK_WIN_BITS-1:2];   // Word offset in the window
    assign idx      = word_ofs[IDX_W-1:0];
    assign in_range = (int'(word_ofs) < NUM_REGS);
    assign access   = psel && m2s.penable;
    assign ready    = access && (wait_cnt == CNT_LAST);

    // ##################################################
    // Wait states
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (access && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // ##################################################
    // Register array
    // ##################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ready && m2s.pwrite && in_range) begin
            regs[idx] <= m2s.pwdata;
        end
    end

    always_comb begin
        s2m.pready  = ready;
        s2m.pslverr = ready && !in_range;   // Past the last register
        s2m.prdata  = '0;
        if (ready && in_range && !m2s.pwrite) begin
            s2m.prdata = regs[idx];
        end
    end

endmodule

`default_nettype wire

// File: src/reg_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_macros.svh"

module reg_subsys_top import reg_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_vld,
    input  reg_req_t req,
    output logic     ack_vld,
    output reg_rsp_t rsp
);

    logic     psel;
    logic     psel0;
    logic     psel1;
    apb_m2s_t m2s;
    apb_s2m_t s2m;
    apb_s2m_t s2m0;
    apb_s2m_t s2m1;

    reg_native_if2apb u_bridge (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .ack_vld (ack_vld),
        .rsp     (rsp),
        .psel    (psel),
        .m2s     (m2s),
        .s2m     (s2m)
    );

    apb_decoder u_dec (
        .psel    (psel),
        .paddr   (m2s.paddr),
        .penable (m2s.penable),
        .s2m0    (s2m0),
        .s2m1    (s2m1),
        .psel0   (psel0),
        .psel1   (psel1),
        .s2m     (s2m)
    );

    // Bank 0 answers at once, bank 1 after two wait states
    apb_reg_bank #(.WAIT_STATES(0), .NUM_REGS(`BANK_REGS)) u_bank0 (
        .clk   (clk),
        .rst_n (rst_n),
        .psel  (psel0),
        .m2s   (m2s),
        .s2m   (s2m0)
    );

    apb_reg_bank #(.WAIT_STATES(2), .NUM_REGS(`BANK_REGS)) u_bank1 (
        .clk   (clk),
        .rst_n (rst_n),
        .psel  (psel1),
        .m2s   (m2s),
        .s2m   (s2m1)
    );

endmodule

`default_nettype wire

// File: verification/reg_subsys_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_macros.svh"

module reg_subsys_assert import reg_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_vld,
    input  reg_req_t req,
    input  logic     ack_vld,
    input  logic     psel,
    input  apb_m2s_t m2s,
    input  apb_s2m_t s2m
);

    int unsigned fail_cnt = 0;   // Read by the testbench at the end of the run
    logic        accept;
    logic        to_bank1;

    // Strobe taken while idle or in the ack cycle
    assign accept   = req_vld && (req.wr_en || req.rd_en) && (!psel || ack_vld);
    assign to_bank1 = ((req.addr >> `BANK_WIN_BITS) == (`BANK1_BASE >> `BANK_WIN_BITS));

    // ##################################################
    // APB phase order and hold
    // ##################################################
    setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !m2s.penable |=> psel && m2s.penable)
        else begin
            fail_cnt++;
            $error("APB setup phase not followed by access phase");
        end

    penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(m2s.penable) |-> $past(psel) && psel)
        else begin
            fail_cnt++;
            $error("penable rose without a setup phase");
        end

    hold_while_wait: assert property (@(posedge clk) disable iff (!rst_n)
        psel && m2s.penable && !s2m.pready |=> psel && m2s.penable
            && $stable(m2s.pwrite) && $stable(m2s.paddr) && $stable(m2s.pwdata))
        else begin
            fail_cnt++;
            $error("APB fields changed while pready was low");
        end

    // ##################################################
    // Ack latency from the strobe
    // ##################################################
    ack_lat_short: assert property (@(posedge clk) disable iff (!rst_n)
        accept && !to_bank1 |-> ##1 !ack_vld ##1 ack_vld)
        else begin
            fail_cnt++;
            $error("Ack not 2 cycles after strobe");
        end

    ack_lat_bank1: assert property (@(posedge clk) disable iff (!rst_n)
        accept && to_bank1 |-> ##1 !ack_vld ##1 !ack_vld ##1 !ack_vld ##1 ack_vld)
        else begin
            fail_cnt++;
            $error("Ack not 4 cycles after strobe to bank 1");
        end

endmodule

`default_nettype wire

// File: verification/reg_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "reg_bus_macros.svh"

module reg_subsys_tb import reg_bus_pkg::*; ();

    localparam int TIMEOUT    = 50;
    localparam int BANK1_WAIT = 2;
    localparam int NUM_WORDS  = 2 * `BANK_REGS;

    logic                   clk;
    logic                   rst_n;
    logic                   req_vld;
    reg_req_t               req;
    logic                   ack_vld;
    reg_rsp_t               rsp;
    logic [`REG_DATA_W-1:0] model [NUM_WORDS];   // Expected register contents
    integer                 seed;
    int                     errors;
    bit                     timed_out;

    reg_subsys_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .ack_vld (ack_vld),
        .rsp     (rsp)
    );

    bind reg_subsys_top reg_subsys_assert u_assert (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .ack_vld (ack_vld),
        .psel    (psel),
        .m2s     (m2s),
        .s2m     (s2m)
    );

    always #10 clk = ~clk;

    // ##################################################
    // Reference model
    // ##################################################
    function automatic logic [`REG_ADDR_W-1:0] bank_addr(input int i);
        return ((i < `BANK_REGS) ? `BANK0_BASE : `BANK1_BASE) + 16'(4 * (i % `BANK_REGS));
    endfunction

    function automatic int page_of(input logic [`REG_ADDR_W-1:0] addr);
        return int'(addr >> `BANK_WIN_BITS);
    endfunction

    function automatic bit addr_err(input logic [`REG_ADDR_W-1:0] addr);
        if (page_of(addr) != page_of(`BANK0_BASE) && page_of(addr) != page_of(`BANK1_BASE))
            return 1'b1;   // Unmapped window
        return int'(addr[`BANK_WIN_BITS-1:0]) >= 4 * `BANK_REGS;
    endfunction

    function automatic logic [3:0] model_idx(input logic [`REG_ADDR_W-1:0] addr);
        return 4'(page_of(addr) * `BANK_REGS + int'(addr[`BANK_WIN_BITS-1:2]));
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // With b2b set the strobe goes out at once in the current ack cycle
    task automatic run_check(input bit wr, input logic [`REG_ADDR_W-1:0] addr,
                             input logic [`REG_DATA_W-1:0] data, input bit b2b);
        bit                     exp_err;
        logic [`REG_DATA_W-1:0] exp_rd;
        int                     exp_lat;
        int                     lat;
        exp_err = addr_err(addr);
        exp_rd  = (exp_err || wr) ? '0 : model[model_idx(addr)];
        exp_lat = (page_of(addr) == page_of(`BANK1_BASE)) ? 2 + BANK1_WAIT : 2;
        if (!timed_out) begin
            if (!b2b) begin
                @(posedge clk);
                #2;
            end
            req_vld     = 1'b1;
            req.wr_en   = wr;
            req.rd_en   = !wr;
            req.addr    = addr;
            req.wr_data = data;
            @(posedge clk);
            #2;
            req_vld = 1'b0;
            lat     = 1;
            while (!ack_vld && lat < TIMEOUT) begin
                @(posedge clk);
                #2;
                lat++;
            end
            if (!ack_vld) begin
                timed_out = 1'b1;
                errors++;
                $display("Timeout: no acknowledge within %0d cycles for address %0h",
                         TIMEOUT, addr);
            end else begin
                check_value("err", 32'(rsp.err), 32'(exp_err));
                check_value("ack latency", 32'(lat), 32'(exp_lat));
                if (!wr)
                    check_value("rd_data", rsp.rd_data, exp_rd);
                if (wr && !exp_err)
                    model[model_idx(addr)] = data;
            end
        end
    endtask

    // ##################################################
    // Stimulus
    // ##################################################
    initial begin
        int                     r;
        logic [`REG_DATA_W-1:0] d;
        logic [`REG_ADDR_W-1:0] a;
        seed      = 32'hf5bc_d604;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_vld   = 1'b0;
        req       = '0;
        errors    = 0;
        timed_out = 1'b0;
        d         = '0;
        for (int i = 0; i < NUM_WORDS; i++)
            model[i] = '0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        check_value("ack_vld after reset", 32'(ack_vld), 32'd0);

        for (int i = 0; i < NUM_WORDS; i++)
            run_check(1'b0, bank_addr(i), '0, 1'b0);

        // Round trips to bank 0 and then to bank 1
        for (int n = 0; n < 12; n++) begin
            r = $random(seed) & 32'h7;
            a = bank_addr(((n < 6) ? 0 : `BANK_REGS) + r);
            d = $random(seed);
            run_check(1'b1, a, d, 1'b0);
            run_check(1'b0, a, '0, 1'b0);
        end

        for (int n = 0; n < 4; n++) begin
            r = $random(seed) & 32'hf;
            d = $random(seed);
            run_check(1'b1, bank_addr(r), d, 1'b0);
            run_check(1'b0, bank_addr(r), '0, 1'b1);
            run_check(1'b1, bank_addr(r ^ 8), ~d, 1'b1);   // Other bank
            run_check(1'b0, bank_addr(r ^ 8), '0, 1'b1);
        end

        // Error responses leave the registers alone
        d = ~model[0];   // Differs from the register that the low index bits alias
        run_check(1'b1, 16'h0400, d, 1'b0);
        run_check(1'b1, `BANK0_BASE + 16'h0020, d, 1'b0);
        run_check(1'b1, `BANK1_BASE + 16'h00fc, ~model[NUM_WORDS-1], 1'b1);
        run_check(1'b0, 16'h0400, '0, 1'b0);
        run_check(1'b0, 16'h0800, '0, 1'b1);
        for (int i = 0; i < NUM_WORDS; i++)
            run_check(1'b0, bank_addr(i), '0, 1'b0);

        repeat (2) @(posedge clk);
        $display("Run finished with %0d check errors and %0d assertion failures",
                 errors, u_dut.u_assert.fail_cnt);
        if (errors == 0 && u_dut.u_assert.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/reg_bus_pkg.sv
src/reg_native_if2apb.sv
src/apb_decoder.sv
src/apb_reg_bank.sv
src/reg_subsys_top.sv
verification/reg_subsys_assert.sv
verification/reg_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module reg_subsys_tb -o sim_reg_subsys

./obj_dir/sim_reg_subsys +verilator+error+limit+1000 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
